/* press_pkg.sv */
`default_nettype none

package press_pkg;

    // Press timing in 1 kHz ticks
    localparam int DEBOUNCE_TICKS   = 20;     // 20 ms of stable high before a press counts
    localparam int LONG_PRESS_TICKS = 1500;   // 1.5 s of hold after debounce
    localparam int TIMER_W          = 11;     // Covers up to 2047 ticks

    // Display data widths
    localparam int BCD_W = 4;                 // One decimal digit
    localparam int SEG_W = 7;                 // Segments g down to a

    // Button FSM states
    typedef enum logic [1:0] {
        idle       = 2'b00,                   // Waiting for the button
        debouncing = 2'b01,                   // Button high, not yet trusted
        pressed    = 2'b10,                   // Accepted press, timing the hold
        long_press = 2'b11                    // Long press reported, wait for release
    } press_state_t;

    // Common-cathode patterns, a segment is lit when its bit is high
    localparam logic [SEG_W-1:0] SEG_TABLE [10] = '{
        7'h3F,                                // 0
        7'h06,                                // 1
        7'h5B,                                // 2
        7'h4F,                                // 3
        7'h66,                                // 4
        7'h6D,                                // 5
        7'h7D,                                // 6
        7'h07,                                // 7
        7'h7F,                                // 8
        7'h6F                                 // 9
    };

endpackage

`default_nettype wire

/* pushbutton_processor.sv */
`timescale 1ns/100ps
`default_nettype none

module pushbutton_processor
    import press_pkg::*;
(
    input  logic clk_1khz,
    input  logic rst_n,
    input  logic pushbutton_i,   // Raw contact, not yet in the clock domain
    output logic count_up,       // One-cycle pulse after a short press
    output logic count_down      // One-cycle pulse when a hold turns long
);

    logic               button_sync;   // Button after the synchronizer flop
    press_state_t       state;
    press_state_t       state_nxt;
    logic [TIMER_W-1:0] timer;         // Shared by debounce and hold timing
    logic [TIMER_W-1:0] timer_nxt;
    logic               up_nxt;
    logic               down_nxt;

    // Single synchronizer stage
    always_ff @(posedge clk_1khz or negedge rst_n) begin
        if (!rst_n) begin
            button_sync <= 1'b0;
        end else begin
            button_sync <= pushbutton_i;
        end
    end

    // Next state, timer and pulse requests
    always_comb begin
        state_nxt = state;
        timer_nxt = timer;
        up_nxt    = 1'b0;   // Pulses only last the cycle they are requested
        down_nxt  = 1'b0;

        case (state)
            idle: begin
                timer_nxt = '0;
                if (button_sync) begin
                    // First high cycle already counts toward debounce
                    state_nxt = debouncing;
                    timer_nxt = TIMER_W'(1);
                end
            end

            debouncing: begin
                if (!button_sync) begin
                    state_nxt = idle;   // Bounce, drop it silently
                    timer_nxt = '0;
                end else if (timer == TIMER_W'(DEBOUNCE_TICKS - 1)) begin
                    state_nxt = pressed;   // This is the last needed high cycle
                    timer_nxt = '0;        // Restart for hold time
                end else begin
                    timer_nxt = timer + TIMER_W'(1);
                end
            end

            pressed: begin
                if (!button_sync) begin
                    // Released early enough for a short press
                    state_nxt = idle;
                    timer_nxt = '0;
                    up_nxt    = 1'b1;
                end else if (timer == TIMER_W'(LONG_PRESS_TICKS - 1)) begin
                    state_nxt = long_press;
                    timer_nxt = '0;
                    down_nxt  = 1'b1;     // Reported once, not on release
                end else begin
                    timer_nxt = timer + TIMER_W'(1);
                end
            end

            long_press: begin
                timer_nxt = '0;
                if (!button_sync) begin
                    state_nxt = idle;     // Release after long press is silent
                end
            end

            default: begin
                state_nxt = idle;
                timer_nxt = '0;
            end
        endcase
    end

    // FSM and timer registers
    always_ff @(posedge clk_1khz or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
            timer <= '0;
        end else begin
            state <= state_nxt;
            timer <= timer_nxt;
        end
    end

    // Registered pulses, high for exactly one cycle
    always_ff @(posedge clk_1khz or negedge rst_n) begin
        if (!rst_n) begin
            count_up   <= 1'b0;
            count_down <= 1'b0;
        end else begin
            count_up   <= up_nxt;     // Falls again on the next edge
            count_down <= down_nxt;
        end
    end

endmodule

`default_nettype wire

/* bcd_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module bcd_counter
    import press_pkg::*;
(
    input  logic             clk_1khz,
    input  logic             rst_n,
    input  logic             count_up,     // Add one
    input  logic             count_down,   // Subtract one
    output logic [BCD_W-1:0] tens,
    output logic [BCD_W-1:0] ones
);

    logic [BCD_W-1:0] tens_nxt;
    logic [BCD_W-1:0] ones_nxt;

    // Decimal step with carry and borrow between digits
    always_comb begin
        tens_nxt = tens;
        ones_nxt = ones;

        case ({count_up, count_down})
            2'b10: begin
                if (ones == BCD_W'(9)) begin
                    ones_nxt = '0;   // Carry into tens
                    tens_nxt = (tens == BCD_W'(9)) ? '0 : tens + BCD_W'(1);   // 99 wraps to 00
                end else begin
                    ones_nxt = ones + BCD_W'(1);
                end
            end

            2'b01: begin
                if (ones == '0) begin
                    ones_nxt = BCD_W'(9);   // Borrow from tens
                    tens_nxt = (tens == '0) ? BCD_W'(9) : tens - BCD_W'(1);   // 00 wraps to 99
                end else begin
                    ones_nxt = ones - BCD_W'(1);
                end
            end

            default: begin
                // No pulse, or both at once, holds the count
                tens_nxt = tens;
                ones_nxt = ones;
            end
        endcase
    end

    // Digit registers
    always_ff @(posedge clk_1khz or negedge rst_n) begin
        if (!rst_n) begin
            tens <= '0;
            ones <= '0;
        end else begin
            tens <= tens_nxt;
            ones <= ones_nxt;
        end
    end

endmodule

`default_nettype wire

/* seven_seg_mux.sv */
`timescale 1ns/100ps
`default_nettype none

module seven_seg_mux
    import press_pkg::*;
(
    input  logic             clk_1khz,
    input  logic             rst_n,
    input  logic [BCD_W-1:0] tens,
    input  logic [BCD_W-1:0] ones,
    output logic [SEG_W-1:0] seg,        // Active high, g down to a
    output logic [1:0]       digit_en    // Bit 0 lights ones, bit 1 lights tens
);

    logic             sel;         // High while the tens digit is lit
    logic [BCD_W-1:0] digit_nxt;   // Digit to show after the next edge

    // Segment lookup with blanking for non-decimal codes
    function automatic logic [SEG_W-1:0] seg_lookup(input logic [BCD_W-1:0] digit);
        logic [SEG_W-1:0] pattern;
        if (digit > BCD_W'(9)) begin
            pattern = '0;   // Dark rather than a garbage glyph
        end else begin
            pattern = SEG_TABLE[digit];
        end
        return pattern;
    endfunction

    // The digit not lit now is the one loaded next
    always_comb begin
        digit_nxt = sel ? ones : tens;
    end

    // Select toggles every clock
    always_ff @(posedge clk_1khz or negedge rst_n) begin
        if (!rst_n) begin
            sel <= 1'b0;   // Ones digit lit out of reset
        end else begin
            sel <= ~sel;
        end
    end

    // Segments follow the select on the same edge
    always_ff @(posedge clk_1khz or negedge rst_n) begin
        if (!rst_n) begin
            seg <= SEG_TABLE[0];   // Counter resets to 00
        end else begin
            seg <= seg_lookup(digit_nxt);
        end
    end

    // One-hot enable straight from the select flop
    assign digit_en = {sel, ~sel};

endmodule

`default_nettype wire

/* press_counter_top.sv */
`timescale 1ns/100ps
`default_nettype none

module press_counter_top
    import press_pkg::*;
(
    input  logic             clk_1khz,
    input  logic             rst_n,
    input  logic             pushbutton_i,   // Raw button pin
    output logic [BCD_W-1:0] tens,           // Count, tens digit
    output logic [BCD_W-1:0] ones,           // Count, ones digit
    output logic [SEG_W-1:0] seg,            // Shared segment lines
    output logic [1:0]       digit_en        // Common-cathode digit enables
);

    logic count_up;     // Short press pulse
    logic count_down;   // Long press pulse

    // Button front end
    pushbutton_processor u_pushbutton_processor (
        .clk_1khz     (clk_1khz),
        .rst_n        (rst_n),
        .pushbutton_i (pushbutton_i),
        .count_up     (count_up),
        .count_down   (count_down)
    );

    // Two-digit count
    bcd_counter u_bcd_counter (
        .clk_1khz   (clk_1khz),
        .rst_n      (rst_n),
        .count_up   (count_up),
        .count_down (count_down),
        .tens       (tens),
        .ones       (ones)
    );

    // Display driver
    seven_seg_mux u_seven_seg_mux (
        .clk_1khz (clk_1khz),
        .rst_n    (rst_n),
        .tens     (tens),
        .ones     (ones),
        .seg      (seg),
        .digit_en (digit_en)
    );

endmodule

`default_nettype wire

/* tb_press_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_press_counter
    import press_pkg::*;
();

    localparam int WAIT_LIMIT = 3000;   // Cycles before a wait gives up
    localparam int LONG_HOLD  = 2500;   // Well past debounce plus long-press time

    logic             clk_1khz;
    logic             rst_n;
    logic             pushbutton_i;
    logic [BCD_W-1:0] tens;
    logic [BCD_W-1:0] ones;
    logic [SEG_W-1:0] seg;
    logic [1:0]       digit_en;

    int          model_value;      // Expected count, 0 to 99
    int          cycle_count;      // Edges since reset release, even means ones lit
    int          mismatch_count;
    int          timeout_count;
    int unsigned seed_word;

    press_counter_top dut0 (
        .clk_1khz     (clk_1khz),
        .rst_n        (rst_n),
        .pushbutton_i (pushbutton_i),
        .tens         (tens),
        .ones         (ones),
        .seg          (seg),
        .digit_en     (digit_en)
    );

    always #50 clk_1khz = ~clk_1khz;   // 100 ns period

    // Display phase model, select starts on ones and flips every clock
    always @(posedge clk_1khz or negedge rst_n) begin
        if (!rst_n) begin
            cycle_count <= 0;
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    // Advance whole cycles, ending 10 ns after the edge where inputs change
    task automatic tick(input int cycles);
        repeat (cycles) begin
            @(posedge clk_1khz);
            #10;
        end
    endtask

    task automatic check_bcd(input string name, input logic [BCD_W-1:0] expected,
                             input logic [BCD_W-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_seg(input string name, input logic [SEG_W-1:0] expected,
                             input logic [SEG_W-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_en(input string name, input logic [1:0] expected,
                            input logic [1:0] actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
            mismatch_count++;
        end
    endtask

    // Both digits against a decimal value
    task automatic compare_count(input int value);
        check_bcd("tens", BCD_W'(value / 10), tens);
        check_bcd("ones", BCD_W'(value % 10), ones);
    endtask

    // Poll until the count shows value, bounded
    task automatic wait_count(input int value);
        logic [BCD_W-1:0] exp_tens;
        logic [BCD_W-1:0] exp_ones;
        int               waited;
        exp_tens = BCD_W'(value / 10);
        exp_ones = BCD_W'(value % 10);
        waited   = 0;
        while ((tens !== exp_tens || ones !== exp_ones) && waited < WAIT_LIMIT) begin
            tick(1);
            waited++;
        end
        if (tens !== exp_tens || ones !== exp_ones) begin
            $display("Timeout at %0t: count never reached %0d within %0d cycles",
                     $time, value, WAIT_LIMIT);
            timeout_count++;
        end
        compare_count(value);   // Shows the digits that were there instead
    endtask

    // Bounce glitches first, then a clean hold, then release
    task automatic press(input int hold, input int glitches);
        int high_len;
        int gap_len;
        int i;
        for (i = 0; i < glitches; i++) begin
            high_len     = 1 + int'($urandom % 9);    // 1 to 9, always under debounce
            gap_len      = 3 + int'($urandom % 10);   // Low long enough for the sync flop
            pushbutton_i = 1'b1;
            tick(high_len);
            pushbutton_i = 1'b0;
            tick(gap_len);
        end
        pushbutton_i = 1'b1;
        tick(hold);           // Zero hold leaves only the glitches
        pushbutton_i = 1'b0;
    endtask

    // Enable and segments for the digit the phase model says is lit
    task automatic lit_digit_ok(input int value);
        if (cycle_count % 2 == 0) begin
            check_en("digit_en", 2'b01, digit_en);   // Even cycles light ones
            check_seg("seg with ones lit", SEG_TABLE[value % 10], seg);
        end else begin
            check_en("digit_en", 2'b10, digit_en);
            check_seg("seg with tens lit", SEG_TABLE[value / 10], seg);
        end
    endtask

    // Two cycles cover both digits
    task automatic scan_display(input int value);
        lit_digit_ok(value);
        tick(1);
        lit_digit_ok(value);
    endtask

    task automatic reset_state();
        compare_count(0);
        scan_display(0);   // Ones lit out of reset, then tens
    endtask

    task automatic wrap_both_ways();
        press(LONG_HOLD, 0);   // 00 down to 99
        model_value = 99;
        wait_count(model_value);
        tick(20);
        press(60 + int'($urandom % 941), 0);   // 99 up to 00
        model_value = 0;
        wait_count(model_value);
        tick(20);
    endtask

    task automatic short_presses();
        int n;
        for (n = 0; n < 12; n++) begin
            press(60 + int'($urandom % 941), 0);
            model_value = (model_value + 1) % 100;
            wait_count(model_value);
            tick(30);
            compare_count(model_value);   // Still one step only
        end
    endtask

    task automatic hold_long();
        int early;
        early        = DEBOUNCE_TICKS + LONG_PRESS_TICKS + 20;
        pushbutton_i = 1'b1;
        tick(early);
        model_value = (model_value + 99) % 100;   // One step down
        wait_count(model_value);                  // Button still held here
        tick(LONG_HOLD - early);
        compare_count(model_value);
        pushbutton_i = 1'b0;
        tick(50);
        compare_count(model_value);   // Release adds nothing
    endtask

    task automatic reject_bounce();
        press(0, 3 + int'($urandom % 4));   // Glitches only
        tick(40);
        compare_count(model_value);
        press(200, 4);                      // Bouncy edge then a real press
        model_value = (model_value + 1) % 100;
        wait_count(model_value);
        tick(30);
        compare_count(model_value);
    endtask

    task automatic display_decode();
        tick(3);   // Let seg catch up with the last count change
        scan_display(model_value);
    endtask

    initial begin
        seed_word      = $urandom(29);
        mismatch_count = 0;
        timeout_count  = 0;
        model_value    = 0;
        clk_1khz       = 1'b0;
        rst_n          = 1'b0;
        pushbutton_i   = 1'b0;

        repeat (10) @(posedge clk_1khz);
        #10;
        rst_n = 1'b1;

        reset_state();
        wrap_both_ways();
        short_presses();
        hold_long();
        reject_bounce();
        display_decode();

        $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
press_pkg.sv
pushbutton_processor.sv
bcd_counter.sv
seven_seg_mux.sv
press_counter_top.sv
tb_press_counter.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_press_counter
FILELIST = project.f
OBJ_DIR  = obj_dir
PASS_MSG = Verification passed

.PHONY: sim clean

# Build, run, and fail unless the pass message shows up
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
